/* compile.f */
source/RetireTypes.sv
source/RegWriteStage.sv
source/RegisterFile.sv
source/TrapCsrUnit.sv
source/RetireCore.sv
bench/RetireChecker.sv
bench/RetireBench.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the retire-core testbench with Verilator, runs it and judges the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=RetireSim

verilator --binary --timing --assert -Wall -Wno-fatal \
    -f compile.f --top-module RetireBench -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    echo "Result: pass"
    exit 0
else
    echo "Result: fail"
    exit 1
fi

/* bench/RetireBench.sv */
// Testbench top that makes clock and reset and applies the retire stimulus table to the DUT and its checker.
`timescale 1ns/1ns
`default_nettype none

module RetireBench import RetireTypes::*;;
    typedef struct packed {
        int       testId;
        logic     valid, regWrite, csrWrite, trapValid, trapReturn, expectRedirect;
        RegType_t regType;
        regAddr_t dst, intRdA, intRdB, fpRdA, fpRdB;
        intWord_t intVal, csrVal, trapVal;
        fpWord_t  fpVal;
        csrAddr_t csrAddr, csrRd;
        TrapCause_t cause;
        addr_t    pc;
    } Entry_t;

    logic clk, rstN, retireValid, retireRegWrite, retireCsrWrite, retireTrapValid;
    logic retireTrapReturn, redirectValid, testsDone;
    RegType_t retireRegType;
    regAddr_t retireDstAddr, intReadAddrA, intReadAddrB, fpReadAddrA, fpReadAddrB;
    intWord_t retireIntValue, retireCsrValue, retireTrapValue;
    intWord_t intReadValueA, intReadValueB, csrReadValue;
    fpWord_t  retireFpValue, fpReadValueA, fpReadValueB;
    csrAddr_t retireCsrAddr, csrReadAddr;
    TrapCause_t retireTrapCause;
    addr_t    retirePc, redirectPc;
    Privilege_t privilege;
    int       testId, errorCount;
    Entry_t   entries[$];
    Entry_t   e, idle;
    bit       redirectSeen;
    bit       timedOut;              // A redirect never showed up.
    logic [31:0] lfsrState = 32'd31;  // Seed.

    RetireCore #(.RegCount(32), .ResetVector(32'h0000_0100)) uut (.*);
    RetireChecker #(.RegCount(32), .ResetVector(32'h0000_0100)) scoreboard (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period.
    end

    // Galois LFSR stepped once per bit taken.
    function automatic logic [63:0] randomValue(input int width);
        logic [63:0] value = '0;
        logic bitOut;
        for (int i = 0; i < width; i++) begin
            bitOut = lfsrState[0];
            lfsrState = (lfsrState >> 1) ^ (bitOut ? 32'h8020_0003 : 32'h0);
            value = {value[62:0], bitOut};
        end
        return value;
    endfunction

    task automatic driveRetire(input Entry_t x);
        retireValid <= x.valid;
        retireRegWrite <= x.regWrite;
        retireRegType <= x.regType;
        retireDstAddr <= x.dst;
        retireIntValue <= x.intVal;
        retireFpValue <= x.fpVal;
        retireCsrWrite <= x.csrWrite;
        retireCsrAddr <= x.csrAddr;
        retireCsrValue <= x.csrVal;
        retireTrapValid <= x.trapValid;
        retireTrapCause <= x.cause;
        retireTrapValue <= x.trapVal;
        retirePc <= x.pc;
        retireTrapReturn <= x.trapReturn;
    endtask

    // Read addresses of an entry go out one cycle after its retirement.
    task automatic driveReads(input Entry_t x);
        intReadAddrA <= x.intRdA;
        intReadAddrB <= x.intRdB;
        fpReadAddrA <= x.fpRdA;
        fpReadAddrB <= x.fpRdB;
        csrReadAddr <= x.csrRd;
    endtask

    task automatic add(input int id);
        e.testId = id;
        entries.push_back(e);
        e = idle;
    endtask

    // The entry under construction writes the integer file.
    task automatic intWrite(input regAddr_t dst, input intWord_t value);
        e.valid = 1'b1;
        e.regWrite = 1'b1;
        e.regType = RegType_Int;
        e.dst = dst;
        e.intVal = value;
    endtask

    task automatic fpWrite(input regAddr_t dst, input fpWord_t value);
        e.valid = 1'b1;
        e.regWrite = 1'b1;
        e.regType = RegType_Fp;
        e.dst = dst;
        e.fpVal = value;
    endtask

    task automatic csrUpdate(input csrAddr_t addr, input intWord_t value);
        e.valid = 1'b1;
        e.csrWrite = 1'b1;
        e.csrAddr = addr;
        e.csrVal = value;
    endtask

    task automatic raiseTrap(input TrapCause_t cause, input intWord_t value, input addr_t pc);
        e.valid = 1'b1;
        e.trapValid = 1'b1;
        e.cause = cause;
        e.trapVal = value;
        e.pc = pc;
        e.expectRedirect = 1'b1;  // Trap entry always redirects.
    endtask

    task automatic returnFromTrap();
        e.valid = 1'b1;
        e.trapReturn = 1'b1;
        e.expectRedirect = 1'b1;
    endtask

    // Idles the retire port until the redirect of the last trap or mret shows up.
    task automatic waitRedirect(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < 4 && !seen; n++) begin
            @(posedge clk);
            driveRetire(idle);
            @(negedge clk);
            seen = redirectValid;
        end
        if (!seen) begin
            $display("redirectValid never rose after a trap or mret");
        end
    endtask

    task automatic buildTable();
        regAddr_t dst;
        idle = '0;
        e = idle;
        // Test 1 covers integer writes, x0 and an FP-typed write aimed at x5.
        intWrite(5, 32'hCAFE_0005);
        add(1);
        intWrite(0, 32'hFFFF_FFFF);
        e.intRdA = 5;
        add(1);
        fpWrite(5, 64'h1);
        e.intVal = 32'h1111_1111;
        e.intRdA = 0;
        e.intRdB = 5;
        add(1);
        for (int i = 0; i < 4; i++) begin
            dst = 5'(randomValue(5));
            intWrite(dst, 32'(randomValue(32)));
            e.intRdA = 5;
            e.intRdB = dst;
            add(1);
        end
        // Test 2 covers full 64-bit FP values, f0 and back-to-back writes to f3.
        fpWrite(0, randomValue(64));
        add(2);
        fpWrite(3, randomValue(64));
        e.fpRdA = 0;
        add(2);
        fpWrite(3, 64'h4009_21FB_5444_2D18);
        e.fpRdA = 3;
        e.fpRdB = 3;
        add(2);
        // Test 3 writes CSRs and reads them back.
        csrUpdate(CsrMscratch, 32'hA5A5_5A5A);
        e.csrRd = CsrMscratch;
        add(3);
        csrUpdate(CsrMtvec, 32'h0000_0403);
        e.csrRd = CsrMtvec;
        add(3);
        csrUpdate(CsrMepc, 32'h0000_1237);
        e.csrRd = CsrMepc;
        add(3);
        csrUpdate(12'h7C0, 32'h1234_5678);
        e.csrRd = 12'h7C0;
        add(3);
        // Test 4 traps with register and CSR writes requested and MIE set beforehand.
        csrUpdate(CsrMstatus, 32'h8);
        e.csrRd = CsrMstatus;
        add(4);
        intWrite(6, 32'hDEAD_BEEF);
        csrUpdate(CsrMscratch, 32'h0);
        raiseTrap(TrapCauseIllegalInstruction, 32'h0000_FFFF, 32'h0000_1000);
        e.intRdA = 6;
        e.csrRd = CsrMepc;
        add(4);
        e.intRdA = 6;
        e.csrRd = CsrMcause;
        add(4);
        e.csrRd = CsrMtval;
        add(4);
        e.csrRd = CsrMscratch;
        add(4);
        // Test 5 reaches User with two mrets, then an ecall from U and an mret back.
        returnFromTrap();
        e.csrRd = CsrMstatus;
        add(5);
        returnFromTrap();
        e.csrRd = CsrMstatus;
        add(5);
        raiseTrap(TrapCauseEcallFromU, 32'h0, 32'h0000_2000);
        e.csrRd = CsrMstatus;
        add(5);
        returnFromTrap();
        e.csrRd = CsrMstatus;
        add(5);
        // Test 6 sends invalid slots with every other field set.
        intWrite(7, '1);
        e.fpVal = '1;
        csrUpdate(CsrMscratch, '1);
        raiseTrap(TrapCauseBreakpoint, '1, 32'h0000_3000);
        returnFromTrap();
        e.valid = 1'b0;
        e.expectRedirect = 1'b0;
        e.csrRd = CsrMscratch;
        add(6);
        fpWrite(7, '1);
        e.valid = 1'b0;
        e.intRdA = 7;
        e.fpRdA = 7;
        e.csrRd = CsrMepc;
        add(6);
    endtask

    initial begin
        rstN = 1'b0;
        testId = 0;
        testsDone = 1'b0;
        timedOut = 1'b0;
        {retireValid, retireRegWrite, retireCsrWrite, retireTrapValid, retireTrapReturn} = '0;
        retireRegType = RegType_Int;
        {retireDstAddr, retireIntValue, retireFpValue, retireCsrAddr, retireCsrValue} = '0;
        {retireTrapCause, retireTrapValue, retirePc} = '0;
        {intReadAddrA, intReadAddrB, fpReadAddrA, fpReadAddrB, csrReadAddr} = '0;
        buildTable();
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i <= entries.size() && !timedOut; i++) begin
            @(posedge clk);
            driveRetire(i < entries.size() ? entries[i] : idle);
            if (i > 0) driveReads(entries[i - 1]);
            if (i < entries.size()) testId <= entries[i].testId;
            if (i < entries.size() && entries[i].expectRedirect) begin
                waitRedirect(redirectSeen);
                timedOut = !redirectSeen;
            end
        end
        @(posedge clk);
        testsDone <= 1'b1;
        @(negedge clk);
        @(posedge clk);
        if (errorCount == 0 && !timedOut) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bench/RetireChecker.sv */
// Reference model of both register files and the CSRs, instantiated by the testbench to check reads and redirects.
`timescale 1ns/1ns
`default_nettype none

module RetireChecker import RetireTypes::*; #(
    parameter int    RegCount    = 32,
    parameter addr_t ResetVector = 32'h0000_0100
) (
    input  logic       clk,
    input  logic       rstN,
    input  int         testId,
    input  logic       testsDone,
    input  logic       retireValid,
    input  logic       retireRegWrite,
    input  RegType_t   retireRegType,
    input  regAddr_t   retireDstAddr,
    input  intWord_t   retireIntValue,
    input  fpWord_t    retireFpValue,
    input  logic       retireCsrWrite,
    input  csrAddr_t   retireCsrAddr,
    input  intWord_t   retireCsrValue,
    input  logic       retireTrapValid,
    input  TrapCause_t retireTrapCause,
    input  intWord_t   retireTrapValue,
    input  addr_t      retirePc,
    input  logic       retireTrapReturn,
    input  regAddr_t   intReadAddrA,
    input  regAddr_t   intReadAddrB,
    input  regAddr_t   fpReadAddrA,
    input  regAddr_t   fpReadAddrB,
    input  csrAddr_t   csrReadAddr,
    input  intWord_t   intReadValueA,
    input  intWord_t   intReadValueB,
    input  fpWord_t    fpReadValueA,
    input  fpWord_t    fpReadValueB,
    input  intWord_t   csrReadValue,
    input  logic       redirectValid,
    input  addr_t      redirectPc,
    input  Privilege_t privilege,
    output int         errorCount
);
    intWord_t modelInt [RegCount];  // Expected integer file in which x0 stays zero.
    fpWord_t  modelFp [RegCount];   // Expected FP file.
    logic [31:0] mtvec, mscratch, mepc, mtval;
    logic [3:0]  mcause;
    logic        mie, mpie;
    logic [1:0]  mpp, priv;
    logic        expRedirect;       // A redirect is due in the current cycle.
    logic [31:0] expRedirectPc;
    int          curTest = 0;       // Test 0 is the idle time before the first entry.
    int          testErrors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    bit          reported = 0;
    // Retire fields are captured at the falling edge and applied at the next rising edge.
    logic v, rw, cw, tv, tr;
    RegType_t rt;
    regAddr_t dst;
    intWord_t iv, cv, tval;
    fpWord_t fv;
    csrAddr_t ca;
    TrapCause_t tc;
    addr_t pc;

    function automatic logic [31:0] expectedCsr(input csrAddr_t a);
        case (a)
            12'h300: return (32'(mie) << 3) | (32'(mpie) << 7) | (32'(mpp) << 11);
            12'h305: return mtvec;
            12'h340: return mscratch;
            12'h341: return mepc;
            12'h342: return {28'h0, mcause};
            12'h343: return mtval;
            default: return 32'h0;  // Unknown CSRs read zero.
        endcase
    endfunction

    task automatic compare(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic reportTest();
        if (curTest > 0) begin
            testsRun++;
            if (testErrors != 0) testsFailed++;
            $display("test %0d finished with %0d errors", curTest, testErrors);
        end
    endtask

    initial errorCount = 0;

    // The model update uses only values captured in the previous half cycle.
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                modelInt[i] = '0;
                modelFp[i] = '0;
            end
            {mscratch, mepc, mtval, mcause, mie, mpie, mpp} = '0;
            mtvec = ResetVector;
            priv = 2'd3;  // Machine mode after reset.
            expRedirect = 1'b0;
            expRedirectPc = '0;
        end else begin
            expRedirect = v && (tv || tr);
            expRedirectPc = tv ? {mtvec[31:2], 2'b00} : mepc;
            if (v && tv) begin  // An exception writes no register and no CSR.
                mepc = pc;
                mcause = tc;
                mtval = tval;
                mpie = mie;
                mie = 1'b0;
                mpp = priv;
                priv = 2'd3;
            end else if (v) begin
                if (rw && rt == RegType_Int && dst != 0) modelInt[dst] = iv;
                if (rw && rt == RegType_Fp) modelFp[dst] = fv;
                if (cw) begin
                    case (ca)
                        12'h300: {mpp, mpie, mie} = {cv[12:11], cv[7], cv[3]};
                        12'h305: mtvec = cv;
                        12'h340: mscratch = cv;
                        12'h341: mepc = {cv[31:2], 2'b00};  // Aligned mepc.
                        12'h342: mcause = cv[3:0];
                        12'h343: mtval = cv;
                        default: ;
                    endcase
                end
                if (tr) begin  // mret.
                    priv = mpp;
                    mie = mpie;
                    mpie = 1'b1;
                    mpp = 2'd0;
                end
            end
        end
    end

    // Outputs are stable mid-cycle, so compare and capture at the falling edge.
    always @(negedge clk) begin
        if (rstN) begin
            if (testId != curTest) begin
                reportTest();
                curTest = testId;
                testErrors = 0;
            end
            compare("intReadValueA", 64'(modelInt[intReadAddrA]), 64'(intReadValueA));
            compare("intReadValueB", 64'(modelInt[intReadAddrB]), 64'(intReadValueB));
            compare("fpReadValueA", modelFp[fpReadAddrA], fpReadValueA);
            compare("fpReadValueB", modelFp[fpReadAddrB], fpReadValueB);
            compare("csrReadValue", 64'(expectedCsr(csrReadAddr)), 64'(csrReadValue));
            compare("privilege", 64'(priv), 64'(privilege));
            compare("redirectValid", 64'(expRedirect), 64'(redirectValid));
            if (expRedirect) compare("redirectPc", 64'(expRedirectPc), 64'(redirectPc));
            if (testsDone && !reported) begin
                reportTest();
                reported = 1;
                $display("tests run %0d, tests failed %0d, errors %0d",
                         testsRun, testsFailed, errorCount);
            end
        end
        {v, rw, dst, iv, fv} = {retireValid, retireRegWrite, retireDstAddr,
                                retireIntValue, retireFpValue};
        rt = retireRegType;
        {cw, ca, cv} = {retireCsrWrite, retireCsrAddr, retireCsrValue};
        {tv, tc, tval, pc, tr} = {retireTrapValid, retireTrapCause, retireTrapValue,
                                  retirePc, retireTrapReturn};
    end

endmodule

`default_nettype wire

/* source/RetireCore.sv */
// Top level of the retire end: register-write stage, integer and FP files and the CSR unit.
`timescale 1ns/1ns
`default_nettype none

module RetireCore import RetireTypes::*; #(
    parameter int    RegCount    = 32,
    parameter addr_t ResetVector = 32'h0000_0100
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       retireValid,
    input  logic       retireRegWrite,
    input  RegType_t   retireRegType,
    input  regAddr_t   retireDstAddr,
    input  intWord_t   retireIntValue,
    input  fpWord_t    retireFpValue,
    input  logic       retireCsrWrite,
    input  csrAddr_t   retireCsrAddr,
    input  intWord_t   retireCsrValue,
    input  logic       retireTrapValid,
    input  TrapCause_t retireTrapCause,
    input  intWord_t   retireTrapValue,
    input  addr_t      retirePc,
    input  logic       retireTrapReturn,
    input  regAddr_t   intReadAddrA,
    input  regAddr_t   intReadAddrB,
    input  regAddr_t   fpReadAddrA,
    input  regAddr_t   fpReadAddrB,
    input  csrAddr_t   csrReadAddr,
    output intWord_t   intReadValueA,
    output intWord_t   intReadValueB,
    output fpWord_t    fpReadValueA,
    output fpWord_t    fpReadValueB,
    output intWord_t   csrReadValue,
    output logic       redirectValid,
    output addr_t      redirectPc,
    output Privilege_t privilege
);
    logic       intWriteEnable;  // Stage to integer file.
    regAddr_t   intWriteAddr;
    intWord_t   intWriteValue;
    logic       fpWriteEnable;   // Stage to FP file.
    regAddr_t   fpWriteAddr;
    fpWord_t    fpWriteValue;
    logic       csrWriteEnable;  // Stage to CSR unit.
    csrAddr_t   csrWriteAddr;
    intWord_t   csrWriteValue;
    logic       trapEnter;
    TrapCause_t trapCause;
    intWord_t   trapValue;
    addr_t      trapPc;
    logic       trapReturn;

    RegWriteStage stage (.*);  // All port names match the nets above.

    RegisterFile #(.RegCount(RegCount), .WordType(intWord_t), .HasZeroRegister(1'b1)) intRegFile (
        .clk, .rstN,
        .writeEnable(intWriteEnable), .writeAddr(intWriteAddr), .writeValue(intWriteValue),
        .readAddrA(intReadAddrA), .readAddrB(intReadAddrB),
        .readValueA(intReadValueA), .readValueB(intReadValueB)
    );

    // f0 is an ordinary register.
    RegisterFile #(.RegCount(RegCount), .WordType(fpWord_t), .HasZeroRegister(1'b0)) fpRegFile (
        .clk, .rstN,
        .writeEnable(fpWriteEnable), .writeAddr(fpWriteAddr), .writeValue(fpWriteValue),
        .readAddrA(fpReadAddrA), .readAddrB(fpReadAddrB),
        .readValueA(fpReadValueA), .readValueB(fpReadValueB)
    );

    TrapCsrUnit #(.ResetVector(ResetVector)) csrUnit (.*);

endmodule

`default_nettype wire

/* source/TrapCsrUnit.sv */
// Machine-mode CSR file with trap entry, mret, privilege state and the pc redirect of the retire core.
`timescale 1ns/1ns
`default_nettype none

module TrapCsrUnit import RetireTypes::*; #(
    parameter addr_t ResetVector = 32'h0000_0100
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       csrWriteEnable,
    input  csrAddr_t   csrWriteAddr,
    input  intWord_t   csrWriteValue,
    input  logic       trapEnter,
    input  TrapCause_t trapCause,
    input  intWord_t   trapValue,
    input  addr_t      trapPc,
    input  logic       trapReturn,
    input  csrAddr_t   csrReadAddr,
    output intWord_t   csrReadValue,
    output logic       redirectValid,
    output addr_t      redirectPc,
    output Privilege_t privilege
);
    logic       mstatusMie;   // Only the implemented mstatus fields are stored.
    logic       mstatusMpie;
    Privilege_t mstatusMpp;
    addr_t      mtvec;        // Trap vector base in direct mode.
    intWord_t   mscratch;
    addr_t      mepc;         // Low two bits are always zero.
    TrapCause_t mcause;       // Exceptions only, so the interrupt bit stays zero.
    intWord_t   mtval;
    intWord_t   mstatusValue; // Assembled view of mstatus for reads.

    always_comb begin
        mstatusValue                     = '0;
        mstatusValue[MstatusMie]         = mstatusMie;
        mstatusValue[MstatusMpie]        = mstatusMpie;
        mstatusValue[MstatusMpp +: 2]    = mstatusMpp;
    end

    // Combinational read port for the decode stage.
    always_comb begin
        case (csrReadAddr)
            CsrMstatus:  csrReadValue = mstatusValue;
            CsrMtvec:    csrReadValue = mtvec;
            CsrMscratch: csrReadValue = mscratch;
            CsrMepc:     csrReadValue = mepc;
            CsrMcause:   csrReadValue = intWord_t'(mcause);  // Zero-extended code.
            CsrMtval:    csrReadValue = mtval;
            default:     csrReadValue = '0;  // Unimplemented CSRs read zero.
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            privilege   <= Privilege_Machine;  // Hart comes out of reset in M-mode.
            mstatusMie  <= 1'b0;
            mstatusMpie <= 1'b0;
            mstatusMpp  <= Privilege_User;
            mtvec       <= ResetVector;
            mscratch    <= '0;
            mepc        <= '0;
            mcause      <= '0;
            mtval       <= '0;
        end else begin
            if (csrWriteEnable) begin
                case (csrWriteAddr)
                    CsrMstatus: begin
                        mstatusMie  <= csrWriteValue[MstatusMie];
                        mstatusMpie <= csrWriteValue[MstatusMpie];
                        // Only User and Machine are legal, so anything else lands in User.
                        mstatusMpp  <= (csrWriteValue[MstatusMpp +: 2] == Privilege_Machine) ?
                                       Privilege_Machine : Privilege_User;
                    end
                    CsrMtvec:    mtvec    <= csrWriteValue;
                    CsrMscratch: mscratch <= csrWriteValue;
                    CsrMepc:     mepc     <= {csrWriteValue[31:2], 2'b00};  // Word aligned.
                    CsrMcause:   mcause   <= csrWriteValue[3:0];
                    CsrMtval:    mtval    <= csrWriteValue;
                    default: ;  // Writes to other addresses are dropped.
                endcase
            end
            if (trapEnter) begin
                mepc        <= {trapPc[31:2], 2'b00};  // Pc of the faulting instruction.
                mcause      <= trapCause;
                mtval       <= trapValue;
                mstatusMpie <= mstatusMie;   // Save the enable and then mask.
                mstatusMie  <= 1'b0;
                mstatusMpp  <= privilege;    // Remember where the trap came from.
                privilege   <= Privilege_Machine;
            end else if (trapReturn) begin
                privilege   <= mstatusMpp;   // Drop back to the saved mode.
                mstatusMie  <= mstatusMpie;
                mstatusMpie <= 1'b1;
                mstatusMpp  <= Privilege_User;  // Least privileged supported mode.
            end
        end
    end

    // Redirect is a one-cycle pulse in the cycle after entry or return.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            redirectValid <= 1'b0;
            redirectPc    <= '0;
        end else begin
            redirectValid <= trapEnter || trapReturn;
            redirectPc    <= trapEnter ? {mtvec[31:2], 2'b00} : mepc;  // Handler or resume pc.
        end
    end

    // The retire stage suppresses CSR side effects of a trapping instruction.
    assert property (@(posedge clk) disable iff (!rstN) !(csrWriteEnable && trapEnter));

endmodule

`default_nettype wire

/* source/RegisterFile.sv */
// Register file with one write and two read ports; the word type picks integer or FP use.
`timescale 1ns/1ns
`default_nettype none

module RegisterFile import RetireTypes::*; #(
    parameter int RegCount        = 32,
    parameter type WordType       = intWord_t,
    parameter bit HasZeroRegister = 1'b1
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     writeEnable,
    input  regAddr_t writeAddr,
    input  WordType  writeValue,
    input  regAddr_t readAddrA,
    input  regAddr_t readAddrB,
    output WordType  readValueA,
    output WordType  readValueB
);
    WordType regs [RegCount];  // Architectural register storage.
    logic    writeAllowed;     // False for a write aimed at a hardwired zero register.

    assign writeAllowed = writeEnable && !(HasZeroRegister && (writeAddr == '0));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;  // All registers start at zero.
            end
        end else if (writeAllowed) begin
            regs[writeAddr] <= writeValue;  // Visible to readers from the next cycle.
        end
    end

    // Reads see the stored state only, never the value being written this cycle.
    always_comb begin
        readValueA = regs[readAddrA];
        readValueB = regs[readAddrB];
        if (HasZeroRegister && (readAddrA == '0)) begin
            readValueA = '0;  // x0 reads zero.
        end
        if (HasZeroRegister && (readAddrB == '0)) begin
            readValueB = '0;
        end
    end

    // The retire stage must never address a register beyond the file.
    assert property (@(posedge clk) disable iff (!rstN)
        writeEnable |-> (int'(writeAddr) < RegCount));

endmodule

`default_nettype wire

/* source/RegWriteStage.sv */
// Retire stage: commits or traps the finished instruction and steers its writes each cycle.
`timescale 1ns/1ns
`default_nettype none

module RegWriteStage import RetireTypes::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       retireValid,
    input  logic       retireRegWrite,
    input  RegType_t   retireRegType,
    input  regAddr_t   retireDstAddr,
    input  intWord_t   retireIntValue,
    input  fpWord_t    retireFpValue,
    input  logic       retireCsrWrite,
    input  csrAddr_t   retireCsrAddr,
    input  intWord_t   retireCsrValue,
    input  logic       retireTrapValid,
    input  TrapCause_t retireTrapCause,
    input  intWord_t   retireTrapValue,
    input  addr_t      retirePc,
    input  logic       retireTrapReturn,
    output logic       intWriteEnable,
    output regAddr_t   intWriteAddr,
    output intWord_t   intWriteValue,
    output logic       fpWriteEnable,
    output regAddr_t   fpWriteAddr,
    output fpWord_t    fpWriteValue,
    output logic       csrWriteEnable,
    output csrAddr_t   csrWriteAddr,
    output intWord_t   csrWriteValue,
    output logic       trapEnter,
    output TrapCause_t trapCause,
    output intWord_t   trapValue,
    output addr_t      trapPc,
    output logic       trapReturn
);
    logic commit;  // The instruction retires without raising an exception.

    always_comb begin
        commit = retireValid && !retireTrapValid;

        intWriteEnable = commit && retireRegWrite && (retireRegType == RegType_Int);
        intWriteAddr   = retireDstAddr;
        intWriteValue  = retireIntValue;

        fpWriteEnable  = commit && retireRegWrite && (retireRegType == RegType_Fp);
        fpWriteAddr    = retireDstAddr;
        fpWriteValue   = retireFpValue;

        csrWriteEnable = commit && retireCsrWrite;  // A faulting CSR instruction has no effect.
        csrWriteAddr   = retireCsrAddr;
        csrWriteValue  = retireCsrValue;

        trapEnter  = retireValid && retireTrapValid;  // Exception wins over every side effect.
        trapCause  = retireTrapCause;
        trapValue  = retireTrapValue;
        trapPc     = retirePc;                        // Saved into mepc by the trap unit.
        trapReturn = commit && retireTrapReturn;      // Only mret exists with two privilege levels.
    end

    // Each instruction has one destination file.
    assert property (@(posedge clk) disable iff (!rstN) !(intWriteEnable && fpWriteEnable));

    // The trap unit would otherwise see entry and return in one cycle.
    assert property (@(posedge clk) disable iff (!rstN) !(trapEnter && trapReturn));

endmodule

`default_nettype wire

/* source/RetireTypes.sv */
// Shared word types, encodings and CSR numbers; imported by every retire-stage module.
`default_nettype none

package RetireTypes;

    typedef logic [31:0] addr_t;     // Instruction address.
    typedef logic [31:0] intWord_t;  // Integer register value.
    typedef logic [63:0] fpWord_t;   // Double-precision register value, also holds singles.
    typedef logic [4:0]  regAddr_t;  // Register number within one file.
    typedef logic [11:0] csrAddr_t;  // CSR number as encoded in the instruction.

    typedef enum logic {
        RegType_Int = 1'b0,  // Destination is the integer file.
        RegType_Fp  = 1'b1   // Destination is the floating-point file.
    } RegType_t;

    typedef enum logic [1:0] {
        Privilege_User    = 2'd0,  // Unprivileged mode.
        Privilege_Machine = 2'd3   // Mode entered on every trap.
    } Privilege_t;

    typedef logic [3:0] TrapCause_t;  // Exception code field of mcause.

    localparam TrapCause_t TrapCauseMisalignedFetch     = 4'd0;
    localparam TrapCause_t TrapCauseIllegalInstruction = 4'd2;
    localparam TrapCause_t TrapCauseBreakpoint         = 4'd3;
    localparam TrapCause_t TrapCauseLoadFault          = 4'd5;
    localparam TrapCause_t TrapCauseStoreFault         = 4'd7;
    localparam TrapCause_t TrapCauseEcallFromU         = 4'd8;
    localparam TrapCause_t TrapCauseEcallFromM         = 4'd11;

    // Machine-mode CSRs implemented by the trap unit.
    localparam csrAddr_t CsrMstatus  = 12'h300;
    localparam csrAddr_t CsrMtvec    = 12'h305;
    localparam csrAddr_t CsrMscratch = 12'h340;
    localparam csrAddr_t CsrMepc     = 12'h341;
    localparam csrAddr_t CsrMcause   = 12'h342;
    localparam csrAddr_t CsrMtval    = 12'h343;

    localparam int MstatusMie  = 3;   // Global interrupt enable.
    localparam int MstatusMpie = 7;   // Enable saved at trap entry.
    localparam int MstatusMpp  = 11;  // Low bit of the two-bit previous privilege.

endpackage

`default_nettype wire
